// ==== progInstr.hex ====
// Instruction words from byte address 0x000, one word per line
// Column one is the word, the comment gives its byte address and assembly
E59F11F8  // 00 LDR   R1, [PC, #0x1F8]   a from 0x200
E59F21F8  // 04 LDR   R2, [PC, #0x1F8]   b from 0x204
E59F31F8  // 08 LDR   R3, [PC, #0x1F8]   c from 0x208
E3A00C08  // 0C MOV   R0, #0x800         Variable memory base
E0814002  // 10 ADD   R4, R1, R2
E5804000  // 14 STR   R4, [R0, #0]
E0424001  // 18 SUB   R4, R2, R1
E5804004  // 1C STR   R4, [R0, #4]
E0040291  // 20 MUL   R4, R1, R2
E5804008  // 24 STR   R4, [R0, #8]
E0614003  // 28 RSB   R4, R1, R3         c - a
E580400C  // 2C STR   R4, [R0, #12]
E1814003  // 30 ORR   R4, R1, R3
E5804010  // 34 STR   R4, [R0, #16]
E0214002  // 38 EOR   R4, R1, R2
E5804014  // 3C STR   R4, [R0, #20]
E1510003  // 40 CMP   R1, R3
C2814003  // 44 ADDGT R4, R1, #3
E5804018  // 48 STR   R4, [R0, #24]
B580401C  // 4C STRLT R4, [R0, #28]      Must not execute
E2805040  // 50 ADD   R5, R0, #0x40
E5156040  // 54 LDR   R6, [R5, #-0x40]   Reads word 0 back
E256600B  // 58 SUBS  R6, R6, #11        Sets Z
1580401C  // 5C STRNE R4, [R0, #28]      Must not execute
EAFFFFFE  // 60 B     0x60               Halt loop

// ==== progData.hex ====
// Constant data words from byte address 0x200, one word per line
// Column one is the word, the comment names the constant
00000005  // a
00000006  // b
00000003  // c

// ==== verilog.f ====
src/armPkg.sv
src/memBus.sv
src/ctrlBus.sv
src/instrDecoder.sv
src/regFile.sv
src/alu.sv
src/condLogic.sv
src/armCore.sv
src/armWrapper.sv
tests/tbArmWrapper.sv

// ==== run.sh ====
#!/bin/sh
set -e

# Memory images are read relative to the project root
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tbArmWrapper -Mdir obj_dir

./obj_dir/VtbArmWrapper | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// ==== tests/tbArmWrapper.sv ====
module tbArmWrapper import armPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// ------------------------------------------------
	// Program constants and run length
	// ------------------------------------------------
	localparam int A            = 5;   // Constant data words
	localparam int B            = 6;
	localparam int C            = 3;
	localparam int RESET_CYCLES = 3;
	localparam int PROG_LEN     = 25;  // Instructions up to the halt loop
	localparam int HALT_CYCLES  = 20;
	localparam int N_WORDS      = 9;
	localparam logic [N_LEDS-1:0] HALT_ADDR = 16'h0060;
	localparam logic [31:0] SEED = 32'h4be1;
	// Two program runs with scans, the halt hold, then margin
	localparam int WATCHDOG_CYCLES =
		3 * (2 * (RESET_CYCLES + 1 + PROG_LEN + 2 * N_WORDS) + HALT_CYCLES);

	logic              CLK;
	logic              RESET;
	logic [N_DIPS-1:0] DIP;
	logic [N_LEDS-1:0] LED;
	logic [WORD_W-1:0] SEVENSEGHEX;

	int checks;
	int fails;
	int checkMark;   // Counts at start of current test
	int failMark;

	// Words probed through DIP
	int wordIdx [N_WORDS] = '{0, 1, 2, 3, 4, 5, 6, 7, 100};

	armWrapper dut0 (
		.CLK(CLK), .RESET(RESET), .DIP(DIP),
		.LED(LED), .SEVENSEGHEX(SEVENSEGHEX)
	);

	always #4 CLK = ~CLK;  // 8 ns period

	// Memory contents the program leaves behind
	function automatic logic [WORD_W-1:0] expectedWord(input int idx);
		case (idx)
			0:       return WORD_W'(A + B);
			1:       return WORD_W'(B - A);
			2:       return WORD_W'(A * B);
			3:       return WORD_W'(C - A);  // Reverse subtract, wraps
			4:       return WORD_W'(A | C);
			5:       return WORD_W'(A ^ B);
			6:       return (A > C) ? WORD_W'(A + 3) : WORD_W'(A ^ B); // ADDGT or stale R4
			default: return '0;              // Blocked stores, untouched words
		endcase
	endfunction

	task automatic expectEqual(
		input logic [WORD_W-1:0] actual,
		input logic [WORD_W-1:0] expected,
		input string             what
	);
		checks++;
		assert (actual === expected) else begin
			fails++;
			$display("mismatch at %0t ns: %s is 0x%h, expected 0x%h",
				$time, what, actual, expected);
		end
	endtask

	task automatic finishTest(input string name);
		$display("test %-24s %s, %0d checks", name,
			(fails == failMark) ? "ok" : "FAILED", checks - checkMark);
		checkMark = checks;
		failMark  = fails;
	endtask

	// ------------------------------------------------
	// Stimulus tasks
	// ------------------------------------------------
	task automatic applyReset();
		@(posedge CLK);
		RESET <= 1'b1;
		repeat (RESET_CYCLES) begin
			@(negedge CLK);
			expectEqual(WORD_W'(LED), '0, "LED in reset");
			expectEqual(SEVENSEGHEX, '0, "SEVENSEGHEX in reset");
			@(posedge CLK);
		end
		RESET <= 1'b0;  // Last reset edge already seen
	endtask

	// LED trails the PC by one edge, PC steps by 4
	task automatic followProgram(input bit freshMemory);
		logic [N_LEDS-1:0] expLed;
		@(posedge CLK);                      // First edge out of reset
		for (int k = 0; k < PROG_LEN; k++) begin
			@(negedge CLK);
			expLed = N_LEDS'(4 * k);
			expectEqual(WORD_W'(LED), WORD_W'(expLed), "LED while stepping");
			if (freshMemory && (k == 0)) begin
				expectEqual(SEVENSEGHEX, '0, "SEVENSEGHEX after reset");
			end
		end
	endtask

	// Probe table slots in a shuffled order
	task automatic scanWords(input int first, input int count);
		int order[$];
		int pick;
		int tmp;
		for (int i = 0; i < count; i++) begin
			order.push_back(first + i);
		end
		for (int i = count - 1; i > 0; i--) begin
			pick        = int'($urandom_range(i, 0));
			tmp         = order[i];
			order[i]    = order[pick];
			order[pick] = tmp;
		end
		foreach (order[j]) begin
			@(posedge CLK);
			DIP <= N_DIPS'(wordIdx[order[j]]);
			@(posedge CLK);                  // Display register loads here
			@(negedge CLK);
			expectEqual(SEVENSEGHEX, expectedWord(wordIdx[order[j]]),
				$sformatf("word %0d", wordIdx[order[j]]));
		end
	endtask

	task automatic holdHalt();
		repeat (HALT_CYCLES) begin
			@(negedge CLK);
			expectEqual(WORD_W'(LED), WORD_W'(HALT_ADDR), "LED at halt");
		end
	endtask

	// ------------------------------------------------
	// Test sequence
	// ------------------------------------------------
	initial begin
		CLK       = 1'b0;
		RESET     = 1'b1;  // Held from time zero
		DIP       = '0;
		checks    = 0;
		fails     = 0;
		checkMark = 0;
		failMark  = 0;
		void'($urandom(SEED));

		applyReset();
		followProgram(1'b1);
		finishTest("1 reset and stepping");
		scanWords(0, 4);
		finishTest("2 arithmetic");
		scanWords(4, 2);
		finishTest("3 logic");
		scanWords(6, 3);
		finishTest("4 conditions");
		holdHalt();
		finishTest("5 halt");

		// Rerun from mid-run reset, memory keeps its words
		applyReset();
		followProgram(1'b0);
		scanWords(0, N_WORDS);
		finishTest("6 mid-run reset");

		$display("checks: %0d run, %0d failed", checks, fails);
		if (fails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== src/armWrapper.sv ====
module armWrapper import armPkg::*; (
	input  logic              CLK,
	input  logic              RESET,        // Active high
	input  logic [N_DIPS-1:0] DIP,          // Picks the displayed word
	output logic [N_LEDS-1:0] LED,          // Low PC bits
	output logic [WORD_W-1:0] SEVENSEGHEX   // Variable memory word
);

	memBus bus ();

	logic [WORD_W-1:0] instrMem [0:MEM_DEPTH-1];
	logic [WORD_W-1:0] constMem [0:MEM_DEPTH-1]; // Read only
	logic [WORD_W-1:0] varMem   [0:MEM_DEPTH-1];
	logic [MEM_AW-1:0] instrIdx;
	logic [MEM_AW-1:0] dataIdx;
	logic              decConst;
	logic              decVar;

	function automatic logic inRange(
		input logic [WORD_W-1:0] addr,
		input logic [WORD_W-1:0] lo,
		input logic [WORD_W-1:0] hi
	);
		return (addr >= lo) && (addr <= hi);
	endfunction

	// ------------------------------------------------
	// Memory images
	// ------------------------------------------------
	initial begin
		$readmemh("progInstr.hex", instrMem);
		$readmemh("progData.hex", constMem);
		for (int i = 0; i < MEM_DEPTH; i++) begin
			varMem[i] = '0;  // Starts cleared
		end
	end

	armCore core0 (.CLK(CLK), .RESET(RESET), .bus(bus));

	// Fetch
	assign instrIdx  = bus.pc[MEM_AW+1:2];
	assign bus.instr = inRange(bus.pc, INSTR_BASE, INSTR_TOP) ? instrMem[instrIdx] : '0;

	// ------------------------------------------------
	// Data address decode and read
	// ------------------------------------------------
	assign dataIdx  = bus.aluResult[MEM_AW+1:2];
	assign decConst = inRange(bus.aluResult, CONST_BASE, CONST_TOP);
	assign decVar   = inRange(bus.aluResult, VAR_BASE, VAR_TOP);

	always_comb begin
		if (decVar)        bus.readData = varMem[dataIdx];
		else if (decConst) bus.readData = constMem[dataIdx];
		else               bus.readData = '0;  // Unmapped
	end

	// Stores land only in variable memory
	always_ff @(posedge CLK) begin
		if (bus.memWrite && decVar) begin
			varMem[dataIdx] <= bus.writeData;
		end
	end

	// ------------------------------------------------
	// Displays
	// ------------------------------------------------
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			LED         <= '0;
			SEVENSEGHEX <= '0;
		end else begin
			LED         <= bus.pc[N_LEDS-1:0];  // Previous cycle PC
			SEVENSEGHEX <= varMem[DIP];         // Word as of last edge
		end
	end

	// Core only issues stores into the writable range
	assert property (@(posedge CLK) disable iff (RESET) bus.memWrite |-> decVar);

endmodule

// ==== src/armCore.sv ====
module armCore import armPkg::*; (
	input  logic CLK,
	input  logic RESET,
	memBus.core  bus
);

	ctrlBus ctrl ();  // Decoded control

	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] pcPlus4;
	logic [WORD_W-1:0] pcPlus8;
	logic [WORD_W-1:0] pcNext;
	logic [WORD_W-1:0] branchTarget;
	logic [WORD_W-1:0] rd1;
	logic [WORD_W-1:0] rd2;
	logic [WORD_W-1:0] rd3;
	logic [WORD_W-1:0] srcB;
	logic [WORD_W-1:0] aluResult;
	logic [WORD_W-1:0] result;      // Write-back value
	logic [3:0]        aluFlags;
	logic              regWriteOk;
	logic              memWriteOk;
	logic              branchTaken;

	// ------------------------------------------------
	// Program counter
	// ------------------------------------------------
	assign pcPlus4      = pc + 32'd4;
	assign pcPlus8      = pc + 32'd8;       // Pipeline-visible PC
	assign branchTarget = pcPlus8 + ctrl.immValue;
	assign pcNext       = branchTaken ? branchTarget : pcPlus4;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) pc <= '0;
		else       pc <= pcNext;
	end

	// Operand 2 and write-back muxes
	assign srcB   = ctrl.aluSrcImm ? ctrl.immValue :
		(ctrl.aluOp == MUL) ? rd3 : rd2;  // Rs for multiply
	assign result = ctrl.memToReg ? bus.readData : aluResult;

	instrDecoder dec0 (.instr(bus.instr), .ctrl(ctrl));

	regFile rf0 (
		.CLK(CLK), .RESET(RESET),
		.ra1(ctrl.rn), .ra2(ctrl.rm), .ra3(ctrl.rs), .wa(ctrl.rd),
		.we(regWriteOk), .wd(result), .pcPlus8(pcPlus8),
		.rd1(rd1), .rd2(rd2), .rd3(rd3)
	);

	alu alu0 (.a(rd1), .b(srcB), .ctrl(ctrl), .result(aluResult), .aluFlags(aluFlags));

	condLogic cond0 (
		.CLK(CLK), .RESET(RESET), .ctrl(ctrl), .aluFlags(aluFlags),
		.regWriteOk(regWriteOk), .memWriteOk(memWriteOk), .branchTaken(branchTaken)
	);

	// Memory side
	assign bus.pc        = pc;
	assign bus.aluResult = aluResult;
	assign bus.writeData = rd3;
	assign bus.memWrite  = memWriteOk;

	// Branch offsets are word multiples, so PC stays aligned
	assert property (@(posedge CLK) disable iff (RESET) pc[1:0] == 2'b00);

endmodule

// ==== src/condLogic.sv ====
module condLogic import armPkg::*; (
	input  logic       CLK,
	input  logic       RESET,
	ctrlBus.sink       ctrl,
	input  logic [3:0] aluFlags,     // N Z C V from the ALU
	output logic       regWriteOk,
	output logic       memWriteOk,
	output logic       branchTaken
);

	logic [3:0] flags;      // Stored NZCV
	logic       n;
	logic       z;
	logic       c;
	logic       v;
	logic       condPass;
	logic       fullUpdate; // C and V written too

	assign {n, z, c, v} = flags;

	// ------------------------------------------------
	// Condition evaluation
	// ------------------------------------------------
	always_comb begin
		case (ctrl.cond)
			EQ:      condPass = z;
			NE:      condPass = !z;
			CS:      condPass = c;
			CC:      condPass = !c;
			MI:      condPass = n;
			PL:      condPass = !n;
			VS:      condPass = v;
			VC:      condPass = !v;
			HI:      condPass = c && !z;
			LS:      condPass = !c || z;
			GE:      condPass = (n == v);
			LT:      condPass = (n != v);
			GT:      condPass = !z && (n == v);
			LE:      condPass = z || (n != v);
			AL:      condPass = 1'b1;
			default: condPass = 1'b0;  // NV never executes
		endcase
	end

	// MUL and logic ops leave C and V alone
	assign fullUpdate = (ctrl.aluOp == ADD) || (ctrl.aluOp == SUB) || (ctrl.aluOp == RSB);

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			flags <= 4'b0000;
		end else if (ctrl.setFlags && condPass) begin
			flags[3:2] <= aluFlags[3:2];      // N Z always
			if (fullUpdate) begin
				flags[1:0] <= aluFlags[1:0];
			end
		end
	end

	assign regWriteOk  = ctrl.regWrite && condPass;
	assign memWriteOk  = ctrl.memWrite && condPass;
	assign branchTaken = ctrl.branch && condPass;

	// A store never also writes a register or sets flags
	assert property (@(posedge CLK) disable iff (RESET)
		ctrl.memWrite |-> !ctrl.regWrite && !ctrl.setFlags);

endmodule

// ==== src/alu.sv ====
module alu import armPkg::*; (
	input  logic [WORD_W-1:0] a,
	input  logic [WORD_W-1:0] b,
	ctrlBus.sink              ctrl,
	output logic [WORD_W-1:0] result,
	output logic [3:0]        aluFlags   // N Z C V
);

	logic [WORD_W-1:0] addX;
	logic [WORD_W-1:0] addY;
	logic              addCin;
	logic [WORD_W:0]   addFull;    // Carry in top bit
	logic [WORD_W-1:0] product;
	logic              isArith;
	logic              overflow;

	// One adder shared by ADD, SUB and RSB
	always_comb begin
		addX   = a;
		addY   = b;
		addCin = 1'b0;
		case (ctrl.aluOp)
			SUB: begin
				addY   = ~b;    // a + ~b + 1
				addCin = 1'b1;
			end
			RSB: begin
				addX   = b;     // b + ~a + 1
				addY   = ~a;
				addCin = 1'b1;
			end
			default: ;
		endcase
	end

	assign addFull  = {1'b0, addX} + {1'b0, addY} + {{WORD_W{1'b0}}, addCin};
	assign product  = a * b;  // Low word only
	assign isArith  = (ctrl.aluOp == ADD) || (ctrl.aluOp == SUB) || (ctrl.aluOp == RSB);

	// Same input signs, different result sign
	assign overflow = (addX[WORD_W-1] == addY[WORD_W-1]) &&
		(addFull[WORD_W-1] != addX[WORD_W-1]);

	always_comb begin
		case (ctrl.aluOp)
			AND:     result = a & b;
			EOR:     result = a ^ b;
			ORR:     result = a | b;
			MOV:     result = b;
			MUL:     result = product;
			default: result = addFull[WORD_W-1:0]; // ADD, SUB, RSB
		endcase
	end

	// C and V only meaningful for the adder ops
	assign aluFlags = {
		result[WORD_W-1],
		(result == '0),
		isArith & addFull[WORD_W],
		isArith & overflow
	};

endmodule

// ==== src/regFile.sv ====
module regFile import armPkg::*; (
	input  logic              CLK,
	input  logic              RESET,
	input  logic [3:0]        ra1,
	input  logic [3:0]        ra2,
	input  logic [3:0]        ra3,
	input  logic [3:0]        wa,
	input  logic              we,
	input  logic [WORD_W-1:0] wd,
	input  logic [WORD_W-1:0] pcPlus8,  // R15 value as seen by reads
	output logic [WORD_W-1:0] rd1,
	output logic [WORD_W-1:0] rd2,
	output logic [WORD_W-1:0] rd3
);

	logic [WORD_W-1:0] regs [0:14];  // R0 to R14

	// Write on the edge, R15 is not stored here
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < 15; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != 4'd15)) begin
			regs[wa] <= wd;
		end
	end

	// ------------------------------------------------
	// Asynchronous reads
	// ------------------------------------------------
	assign rd1 = (ra1 == 4'd15) ? pcPlus8 : regs[ra1];
	assign rd2 = (ra2 == 4'd15) ? pcPlus8 : regs[ra2];
	assign rd3 = (ra3 == 4'd15) ? pcPlus8 : regs[ra3]; // Store data or Rs

endmodule

// ==== src/instrDecoder.sv ====
module instrDecoder import armPkg::*; (
	input  logic [WORD_W-1:0] instr,
	ctrlBus.dec               ctrl
);

	logic                isMul;
	logic                isDp;
	logic                isMem;
	logic                isBranch;
	logic [2*WORD_W-1:0] rotSpan;  // Doubled word for rotate
	logic [WORD_W-1:0]   rotImm;

	// ------------------------------------------------
	// Instruction class
	// ------------------------------------------------
	assign isMul    = (instr[27:22] == 6'b000000) && (instr[7:4] == 4'b1001);
	assign isDp     = (instr[27:26] == 2'b00) && !isMul;
	assign isMem    = (instr[27:26] == 2'b01);
	assign isBranch = (instr[27:26] == 2'b10);

	// imm8 rotated right by twice the rot field
	assign rotSpan = {2{{24'b0, instr[7:0]}}} >> {instr[11:8], 1'b0};
	assign rotImm  = rotSpan[WORD_W-1:0];

	always_comb begin
		// Defaults, data processing field layout
		ctrl.cond      = instr[31:28];
		ctrl.rn        = instr[19:16];
		ctrl.rm        = instr[3:0];
		ctrl.rd        = instr[15:12];
		ctrl.rs        = instr[15:12];  // Store data register
		ctrl.aluOp     = ADD;
		ctrl.aluSrcImm = 1'b0;
		ctrl.immValue  = '0;
		ctrl.regWrite  = 1'b0;
		ctrl.memWrite  = 1'b0;
		ctrl.memToReg  = 1'b0;
		ctrl.branch    = 1'b0;
		ctrl.setFlags  = 1'b0;

		if (isMul) begin
			// Rd = Rm * Rs, Rd sits in the Rn slot
			ctrl.aluOp    = MUL;
			ctrl.rn       = instr[3:0];
			ctrl.rd       = instr[19:16];
			ctrl.rs       = instr[11:8];
			ctrl.regWrite = 1'b1;
			ctrl.setFlags = instr[20];
		end else if (isDp) begin
			ctrl.aluSrcImm = instr[25];  // I bit
			ctrl.immValue  = rotImm;
			ctrl.setFlags  = instr[20];
			ctrl.regWrite  = 1'b1;
			case (instr[24:21])
				4'b0000: ctrl.aluOp = AND;
				4'b0001: ctrl.aluOp = EOR;
				4'b0010: ctrl.aluOp = SUB;
				4'b0011: ctrl.aluOp = RSB;
				4'b0100: ctrl.aluOp = ADD;
				4'b1100: ctrl.aluOp = ORR;
				4'b1101: ctrl.aluOp = MOV;
				4'b1010: begin  // CMP, flags only
					ctrl.aluOp    = SUB;
					ctrl.setFlags = 1'b1;
					ctrl.regWrite = 1'b0;
				end
				default: ctrl.regWrite = 1'b0; // Unsupported, no effect
			endcase
		end else if (isMem) begin
			// Immediate offset, U bit picks direction
			ctrl.aluOp     = instr[23] ? ADD : SUB;
			ctrl.aluSrcImm = 1'b1;
			ctrl.immValue  = {20'b0, instr[11:0]};
			ctrl.regWrite  = instr[20];   // LDR
			ctrl.memToReg  = instr[20];
			ctrl.memWrite  = !instr[20];  // STR
		end else if (isBranch) begin
			ctrl.branch   = 1'b1;
			ctrl.immValue = {{6{instr[23]}}, instr[23:0], 2'b00}; // Word offset in bytes
		end
	end

endmodule

// ==== src/ctrlBus.sv ====
interface ctrlBus import armPkg::*; ();

	aluOp_t            aluOp;
	logic              aluSrcImm;  // Operand 2 from immValue
	logic [WORD_W-1:0] immValue;   // Rotated imm, mem offset or branch offset
	logic              regWrite;   // Before condition check
	logic              memWrite;   // Before condition check
	logic              memToReg;   // Write back load data
	logic              branch;
	logic              setFlags;   // S bit, forced for CMP
	logic [3:0]        cond;

	// Register addresses
	logic [3:0]        rn;
	logic [3:0]        rm;
	logic [3:0]        rd;         // Destination
	logic [3:0]        rs;         // Store data or multiplier operand

	modport dec (
		output aluOp, aluSrcImm, immValue,
		output regWrite, memWrite, memToReg, branch, setFlags, cond,
		output rn, rm, rd, rs
	);

	modport sink (
		input  aluOp, aluSrcImm, immValue,
		input  regWrite, memWrite, memToReg, branch, setFlags, cond,
		input  rn, rm, rd, rs
	);

endinterface

// ==== src/memBus.sv ====
interface memBus import armPkg::*; ();

	// Fetch side
	logic [WORD_W-1:0] pc;         // Byte address of current instruction
	logic [WORD_W-1:0] instr;      // Combinational fetch

	// Data side
	logic [WORD_W-1:0] aluResult;  // Data address
	logic [WORD_W-1:0] writeData;  // Store data
	logic              memWrite;   // Already condition gated
	logic [WORD_W-1:0] readData;   // Zero outside data ranges

	modport core (
		output pc,
		output aluResult,
		output writeData,
		output memWrite,
		input  instr,
		input  readData
	);

	modport mem (
		input  pc,
		input  aluResult,
		input  writeData,
		input  memWrite,
		output instr,
		output readData
	);

endinterface

// ==== src/armPkg.sv ====
package armPkg;

	// ------------------------------------------------
	// Widths and sizes
	// ------------------------------------------------
	localparam int WORD_W    = 32;   // Data and address width
	localparam int MEM_DEPTH = 128;  // Words in each memory
	localparam int MEM_AW    = 7;    // Word index width
	localparam int N_LEDS    = 16;   // LED display width
	localparam int N_DIPS    = 7;    // DIP switch width

	// ------------------------------------------------
	// Memory map, byte addresses
	// ------------------------------------------------
	localparam logic [WORD_W-1:0] INSTR_BASE = 32'h0000_0000;
	localparam logic [WORD_W-1:0] INSTR_TOP  = 32'h0000_01FC;
	localparam logic [WORD_W-1:0] CONST_BASE = 32'h0000_0200; // Read-only data
	localparam logic [WORD_W-1:0] CONST_TOP  = 32'h0000_03FC;
	localparam logic [WORD_W-1:0] VAR_BASE   = 32'h0000_0800; // Writable data
	localparam logic [WORD_W-1:0] VAR_TOP    = 32'h0000_09FC;

	// ALU operations
	typedef enum logic [3:0] {
		AND = 4'h0,
		EOR = 4'h1,
		SUB = 4'h2,
		RSB = 4'h3,  // b - a
		ADD = 4'h4,
		ORR = 4'h5,
		MOV = 4'h6,  // Passes operand 2
		MUL = 4'h7   // Low word of product
	} aluOp_t;

	// Condition field, instr[31:28]
	localparam logic [3:0] EQ = 4'b0000;
	localparam logic [3:0] NE = 4'b0001;
	localparam logic [3:0] CS = 4'b0010; // Also HS
	localparam logic [3:0] CC = 4'b0011; // Also LO
	localparam logic [3:0] MI = 4'b0100;
	localparam logic [3:0] PL = 4'b0101;
	localparam logic [3:0] VS = 4'b0110;
	localparam logic [3:0] VC = 4'b0111;
	localparam logic [3:0] HI = 4'b1000; // Unsigned higher
	localparam logic [3:0] LS = 4'b1001;
	localparam logic [3:0] GE = 4'b1010; // Signed compares from here
	localparam logic [3:0] LT = 4'b1011;
	localparam logic [3:0] GT = 4'b1100;
	localparam logic [3:0] LE = 4'b1101;
	localparam logic [3:0] AL = 4'b1110; // Always

endpackage
